// File: design/ooo_issue_pkg.sv
// Shared widths, vector typedefs, ALU opcode enum and ALU function
`default_nettype none

package ooo_issue_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////
    localparam int TAG_W    = 4;            // 16 physical registers
    localparam int DATA_W   = 16;           // Register value width
    localparam int NUM_REGS = 1 << TAG_W;

    typedef logic [TAG_W-1:0]  tag_t;       // Physical register name
    typedef logic [DATA_W-1:0] data_t;      // Register value
    // Layout: op [15:12], dest [11:8], src1 [7:4], src2 [3:0]
    typedef logic [15:0]       inst_word_t;

    // Opcodes; any code not listed falls back to ADD
    typedef enum logic [3:0] {
        OP_ADD = 4'h0,
        OP_SUB = 4'h1,
        OP_AND = 4'h2,
        OP_OR  = 4'h3,
        OP_XOR = 4'h4,
        OP_SHL = 4'h5,
        OP_SHR = 4'h6
    } alu_op_e;

    // Single-cycle ALU, shared with the testbench model
    function automatic data_t alu_compute(alu_op_e op, data_t a, data_t b);
        data_t res;
        case (op)
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_SHL:  res = a << b[3:0];   // Shift amount is src2 low nibble
            OP_SHR:  res = a >> b[3:0];
            default: res = a + b;         // ADD and undefined codes
        endcase
        return res;
    endfunction

endpackage

`default_nettype wire

// File: design/slot_allocator.sv
// Slot allocator: free mask register and lowest-free one-hot grant
`timescale 1ns/1ps
`default_nettype none

module slot_allocator #(
    parameter  int RS_SIZE = 4,
    localparam int IDX_W   = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               flush,        // Frees every slot
    input  logic               req,          // Dispatch wants a slot
    input  logic               clear_valid,  // Issued slot returns
    input  logic [IDX_W-1:0]   clear_idx,
    output logic [RS_SIZE-1:0] grant         // One-hot, zero when nothing free
);

    logic [RS_SIZE-1:0] free_mask;           // 1 = slot free
    logic [RS_SIZE-1:0] free_mask_d;
    logic [RS_SIZE-1:0] lowest_free;

    //////////////////////////////////////////////////
    // Grant
    //////////////////////////////////////////////////
    // Isolate lowest set bit of the mask
    assign lowest_free = free_mask & (~free_mask + 1'b1);
    assign grant       = req ? lowest_free : '0;

    //////////////////////////////////////////////////
    // Mask update
    //////////////////////////////////////////////////
    always_comb begin
        free_mask_d = free_mask;
        // A slot cleared this cycle is still busy in free_mask, so no overlap
        if (clear_valid) begin
            free_mask_d[clear_idx] = 1'b1;
        end
        free_mask_d = free_mask_d & ~grant;  // Granted slot now taken
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            free_mask <= '1;                 // Everything free
        end else if (flush) begin
            free_mask <= '1;
        end else begin
            free_mask <= free_mask_d;
        end
    end

endmodule

`default_nettype wire

// File: design/inst_decode.sv
// Instruction decode: field split, source ready lookup, destination pending request
`timescale 1ns/1ps
`default_nettype none

module inst_decode import ooo_issue_pkg::*; (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       inst_valid,        // One-cycle strobe from outside
    input  inst_word_t inst_word,
    input  logic       stall,             // Station full
    input  logic       src1_ready_in,     // Ready table lookups
    input  logic       src2_ready_in,
    output logic       alloc_valid,
    output alu_op_e    alloc_op,
    output tag_t       alloc_dest,
    output tag_t       alloc_src1,
    output tag_t       alloc_src2,
    output logic       alloc_src1_ready,
    output logic       alloc_src2_ready,
    output logic       mark_pending,      // Clear dest ready bit at dispatch edge
    output tag_t       pending_tag
);

    //////////////////////////////////////////////////
    // Field split
    //////////////////////////////////////////////////
    assign alloc_op   = alu_op_e'(inst_word[15:12]);
    assign alloc_dest = inst_word[11:8];
    assign alloc_src1 = inst_word[7:4];   // Also drives the ready query
    assign alloc_src2 = inst_word[3:0];

    assign alloc_src1_ready = src1_ready_in;
    assign alloc_src2_ready = src2_ready_in;

    // Strobe under stall is dropped here
    assign alloc_valid  = inst_valid & ~stall;

    // Destination goes pending at the same edge the entry is written
    assign mark_pending = alloc_valid;
    assign pending_tag  = alloc_dest;

endmodule

`default_nettype wire

// File: design/rs.sv
// Reservation station: entry array, slot allocator, free count, wakeup and clear
`timescale 1ns/1ps
`default_nettype none

module rs import ooo_issue_pkg::*; #(
    parameter  int RS_SIZE = 4,
    localparam int IDX_W   = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1,
    localparam int CNT_W   = $clog2(RS_SIZE + 1)
) (
    input  logic                    clock,
    input  logic                    rst_n,
    input  logic                    flush,
    // Dispatch side
    input  logic                    alloc_valid,
    input  alu_op_e                 alloc_op,
    input  tag_t                    alloc_dest,
    input  tag_t                    alloc_src1,
    input  tag_t                    alloc_src2,
    input  logic                    alloc_src1_ready,
    input  logic                    alloc_src2_ready,
    // Wakeup from result bus
    input  logic                    bcast_valid,
    input  tag_t                    bcast_tag,
    // Clear from select
    input  logic                    clear_valid,
    input  logic [IDX_W-1:0]        clear_idx,
    // Registered array out
    output logic [RS_SIZE-1:0]      entry_valid,
    output logic [RS_SIZE-1:0][1:0] entry_ready,   // [0] src1, [1] src2
    output alu_op_e [RS_SIZE-1:0]   entry_op,
    output tag_t [RS_SIZE-1:0]      entry_dest,
    output tag_t [RS_SIZE-1:0]      entry_src1,
    output tag_t [RS_SIZE-1:0]      entry_src2,
    output logic [CNT_W-1:0]        free_slots
);

    logic [RS_SIZE-1:0]      valid_q, valid_d;
    logic [RS_SIZE-1:0][1:0] ready_q, ready_d;
    alu_op_e [RS_SIZE-1:0]   op_q, op_d;
    tag_t [RS_SIZE-1:0]      dest_q, dest_d;
    tag_t [RS_SIZE-1:0]      src1_q, src1_d;
    tag_t [RS_SIZE-1:0]      src2_q, src2_d;
    logic [CNT_W-1:0]        free_q, free_d;
    logic [RS_SIZE-1:0]      grant;                // One-hot write slot

    slot_allocator #(.RS_SIZE(RS_SIZE)) slot_alloc_i (
        .clock       (clock),
        .rst_n       (rst_n),
        .flush       (flush),
        .req         (alloc_valid),
        .clear_valid (clear_valid),
        .clear_idx   (clear_idx),
        .grant       (grant)
    );

    //////////////////////////////////////////////////
    // Next array: clear, then write, then wakeup
    //////////////////////////////////////////////////
    always_comb begin
        valid_d = valid_q;
        ready_d = ready_q;
        op_d    = op_q;
        dest_d  = dest_q;
        src1_d  = src1_q;
        src2_d  = src2_q;
        free_d  = free_q;
        if (clear_valid) begin                     // Issued entry leaves
            valid_d[clear_idx] = 1'b0;
            free_d             = free_d + 1'b1;
        end
        for (int i = 0; i < RS_SIZE; i++) begin
            if (grant[i]) begin
                valid_d[i] = 1'b1;
                ready_d[i] = {alloc_src2_ready, alloc_src1_ready};
                op_d[i]    = alloc_op;
                dest_d[i]  = alloc_dest;
                src1_d[i]  = alloc_src1;
                src2_d[i]  = alloc_src2;
            end
        end
        if (|grant) free_d = free_d - 1'b1;
        // Tag match also covers the entry written this cycle
        for (int i = 0; i < RS_SIZE; i++) begin
            if (valid_d[i] && bcast_valid) begin
                if (src1_d[i] == bcast_tag) ready_d[i][0] = 1'b1;
                if (src2_d[i] == bcast_tag) ready_d[i][1] = 1'b1;
            end
        end
    end

    // Control state
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ready_q <= '0;
            free_q  <= CNT_W'(RS_SIZE);
        end else if (flush) begin                  // Mispredict empties the station
            valid_q <= '0;
            ready_q <= '0;
            free_q  <= CNT_W'(RS_SIZE);
        end else begin
            valid_q <= valid_d;
            ready_q <= ready_d;
            free_q  <= free_d;
        end
    end

    // Entry payload
    always_ff @(posedge clock) begin
        op_q   <= op_d;
        dest_q <= dest_d;
        src1_q <= src1_d;
        src2_q <= src2_d;
    end

    assign entry_valid = valid_q;
    assign entry_ready = ready_q;
    assign entry_op    = op_q;
    assign entry_dest  = dest_q;
    assign entry_src1  = src1_q;
    assign entry_src2  = src2_q;
    assign free_slots  = free_q;

endmodule

`default_nettype wire

// File: design/issue_select.sv
// Issue select: lowest-index ready entry pick, field forward and clear pulse
`timescale 1ns/1ps
`default_nettype none

module issue_select import ooo_issue_pkg::*; #(
    parameter  int RS_SIZE = 4,
    localparam int IDX_W   = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1
) (
    input  logic [RS_SIZE-1:0]      entry_valid,
    input  logic [RS_SIZE-1:0][1:0] entry_ready,
    input  alu_op_e [RS_SIZE-1:0]   entry_op,
    input  tag_t [RS_SIZE-1:0]      entry_dest,
    input  tag_t [RS_SIZE-1:0]      entry_src1,
    input  tag_t [RS_SIZE-1:0]      entry_src2,
    output logic                    clear_valid,   // Frees the picked slot
    output logic [IDX_W-1:0]        clear_idx,
    output logic                    issue_valid,
    output alu_op_e                 issue_op,
    output tag_t                    issue_dest,
    output tag_t                    issue_src1,
    output tag_t                    issue_src2
);

    always_comb begin
        clear_valid = 1'b0;
        clear_idx   = '0;
        issue_op    = OP_ADD;
        issue_dest  = '0;
        issue_src1  = '0;
        issue_src2  = '0;
        // Walk down so the lowest eligible index is the last to win
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (entry_valid[i] && (&entry_ready[i])) begin
                clear_valid = 1'b1;
                clear_idx   = IDX_W'(i);
                issue_op    = entry_op[i];
                issue_dest  = entry_dest[i];
                issue_src1  = entry_src1[i];
                issue_src2  = entry_src2[i];
            end
        end
    end

    assign issue_valid = clear_valid;  // One issue per cycle

endmodule

`default_nettype wire

// File: design/alu_execute.sv
// Execute stage: operand read and registered single-cycle ALU
`timescale 1ns/1ps
`default_nettype none

module alu_execute import ooo_issue_pkg::*; (
    input  logic    clock,
    input  logic    rst_n,
    input  logic    flush,        // Drops the instruction being issued
    input  logic    issue_valid,
    input  alu_op_e issue_op,
    input  tag_t    issue_dest,
    input  tag_t    issue_src1,
    input  tag_t    issue_src2,
    output tag_t    rd1_addr,     // Register file read ports
    output tag_t    rd2_addr,
    input  data_t   rd1_data,
    input  data_t   rd2_data,
    output logic    wb_valid,     // One-cycle write-back
    output tag_t    wb_tag,
    output data_t   wb_data
);

    data_t alu_result;

    //////////////////////////////////////////////////
    // Operand read and compute
    //////////////////////////////////////////////////
    assign rd1_addr   = issue_src1;
    assign rd2_addr   = issue_src2;
    assign alu_result = alu_compute(issue_op, rd1_data, rd2_data);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid & ~flush;   // Flush kills it here
        end
    end

    // Result payload, only loaded on issue
    always_ff @(posedge clock) begin
        if (issue_valid) begin
            wb_tag  <= issue_dest;
            wb_data <= alu_result;
        end
    end

endmodule

`default_nettype wire

// File: design/result_bus.sv
// Result stage: physical register file, ready table and tag broadcast
`timescale 1ns/1ps
`default_nettype none

module result_bus import ooo_issue_pkg::*; (
    input  logic  clock,
    input  logic  rst_n,
    input  logic  flush,          // All registers ready again
    input  logic  wb_valid,
    input  tag_t  wb_tag,
    input  data_t wb_data,
    input  logic  mark_pending,   // From decode at dispatch
    input  tag_t  pending_tag,
    input  tag_t  rd1_addr,
    input  tag_t  rd2_addr,
    output data_t rd1_data,
    output data_t rd2_data,
    input  tag_t  src1_tag,       // Ready queries
    input  tag_t  src2_tag,
    output logic  src1_ready,
    output logic  src2_ready,
    output logic  bcast_valid,    // Wakeup to the station
    output tag_t  bcast_tag,
    output logic  result_valid,
    output tag_t  result_tag,
    output data_t result_data
);

    data_t               regs [NUM_REGS];
    logic [NUM_REGS-1:0] ready_q;

    //////////////////////////////////////////////////
    // Register file and ready table
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= DATA_W'(i);             // Register i starts at i
            end
            ready_q <= '1;
        end else begin
            if (wb_valid) regs[wb_tag] <= wb_data; // Still commits during flush
            if (flush) begin
                ready_q <= '1;
            end else begin
                if (wb_valid)     ready_q[wb_tag]      <= 1'b1;
                if (mark_pending) ready_q[pending_tag] <= 1'b0; // Newer producer wins
            end
        end
    end

    assign rd1_data   = regs[rd1_addr];
    assign rd2_data   = regs[rd2_addr];
    assign src1_ready = ready_q[src1_tag];
    assign src2_ready = ready_q[src2_tag];

    // Broadcast and result mirror the write-back cycle
    assign bcast_valid  = wb_valid;
    assign bcast_tag    = wb_tag;
    assign result_valid = wb_valid;
    assign result_tag   = wb_tag;
    assign result_data  = wb_data;

endmodule

`default_nettype wire

// File: design/ooo_issue_top.sv
// Top level: decode, reservation station, select, execute and result stage
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_top import ooo_issue_pkg::*; #(
    parameter  int RS_SIZE = 4,
    localparam int IDX_W   = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1,
    localparam int CNT_W   = $clog2(RS_SIZE + 1)
) (
    input  logic       clock,
    input  logic       rst_n,
    input  logic       inst_valid,
    input  inst_word_t inst_word,
    input  logic       flush,
    output logic       stall,
    output logic       result_valid,
    output tag_t       result_tag,
    output data_t      result_data
);

    logic alloc_valid, alloc_src1_ready, alloc_src2_ready, mark_pending;
    alu_op_e alloc_op, issue_op;
    tag_t alloc_dest, alloc_src1, alloc_src2, pending_tag;
    logic src1_ready, src2_ready, bcast_valid, clear_valid, issue_valid, wb_valid;
    tag_t bcast_tag, issue_dest, issue_src1, issue_src2, rd1_addr, rd2_addr, wb_tag;
    data_t rd1_data, rd2_data, wb_data;
    logic [IDX_W-1:0]        clear_idx;
    logic [CNT_W-1:0]        free_slots;
    logic [RS_SIZE-1:0]      entry_valid;
    logic [RS_SIZE-1:0][1:0] entry_ready;
    alu_op_e [RS_SIZE-1:0]   entry_op;
    tag_t [RS_SIZE-1:0]      entry_dest, entry_src1, entry_src2;

    assign stall = (free_slots == '0);   // Station full

    inst_decode decode_i (.*, .src1_ready_in(src1_ready), .src2_ready_in(src2_ready));

    rs #(.RS_SIZE(RS_SIZE)) rs_i (.*);

    issue_select #(.RS_SIZE(RS_SIZE)) select_i (.*);

    alu_execute execute_i (.*);

    result_bus result_i (.*, .src1_tag(alloc_src1), .src2_tag(alloc_src2));

endmodule

`default_nettype wire

// File: verif/clock_gen.sv
// Testbench clock and active-low reset generator
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 100,
    parameter int RESET_CYCLES = 4
) (
    output logic clock,
    output logic rst_n
);

    initial begin
        clock = 1'b0;
        forever #(PERIOD_NS / 2) clock = ~clock;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);                  // Release away from the rising edge
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/ooo_issue_properties.sv
// Bound assertions: no strobe under stall, quiet result bus after reset, cleared slot empties
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_properties #(
    parameter  int RS_SIZE = 4,
    localparam int IDX_W   = (RS_SIZE > 1) ? $clog2(RS_SIZE) : 1
) (
    input logic               clock,
    input logic               rst_n,
    input logic               inst_valid,
    input logic               stall,
    input logic               result_valid,
    input logic               clear_valid,
    input logic [IDX_W-1:0]   clear_idx,
    input logic [RS_SIZE-1:0] entry_valid
);

    // Strobe while full would be dropped silently
    no_strobe_on_stall: assert property (@(posedge clock) disable iff (!rst_n)
        !(inst_valid && stall))
        else $error("inst_valid strobed while stall is high");

    quiet_after_reset: assert property (@(posedge clock) $rose(rst_n) |-> !result_valid)
        else $error("result_valid high right after reset");

    // Cleared slot is empty the next cycle, so it cannot be cleared twice
    clear_frees_slot: assert property (@(posedge clock) disable iff (!rst_n)
        clear_valid |=> !entry_valid[$past(clear_idx)])
        else $error("slot %0d still holds an entry after its clear", $past(clear_idx));

endmodule

bind ooo_issue_top ooo_issue_properties #(.RS_SIZE(RS_SIZE)) props_i (
    .clock        (clock),
    .rst_n        (rst_n),
    .inst_valid   (inst_valid),
    .stall        (stall),
    .result_valid (result_valid),
    .clear_valid  (clear_valid),
    .clear_idx    (clear_idx),
    .entry_valid  (entry_valid)
);

`default_nettype wire

// File: verif/ooo_issue_tb.sv
// Testbench: stimulus, reference model, result compare process and checks
`timescale 1ns/1ps
`default_nettype none

module ooo_issue_tb import ooo_issue_pkg::*; ();

    localparam int RS_SIZE = 4;
    localparam int TIMEOUT = 400;          // Cycles allowed for any single wait

    logic       clock, rst_n, inst_valid, flush, stall, result_valid;
    inst_word_t inst_word;
    tag_t       result_tag;
    data_t      result_data;

    //////////////////////////////////////////////////
    // Model state
    //////////////////////////////////////////////////
    data_t      model_regs [16];           // Written by the compare process only
    logic [3:0] pend_op [16];              // In-flight instruction, keyed by dest
    tag_t       pend_s1 [16];
    tag_t       pend_s2 [16];
    int         issued [16]    = '{default: 0};
    int         retired [16]   = '{default: 0};
    int         dropped [16]   = '{default: 0};  // Lost to a flush
    integer     seed           = 68;
    bit         stall_seen     = 1'b0;

    clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(4)) clk_i (.clock(clock), .rst_n(rst_n));

    ooo_issue_top #(.RS_SIZE(RS_SIZE)) dut_i (.*);

    // Expected ALU result, straight from the opcode table
    function automatic data_t ref_alu(logic [3:0] op, data_t a, data_t b);
        case (op)
            4'h1:    return a - b;
            4'h2:    return a & b;
            4'h3:    return a | b;
            4'h4:    return a ^ b;
            4'h5:    return a << b[3:0];
            4'h6:    return a >> b[3:0];
            default: return a + b;         // ADD and unused codes
        endcase
    endfunction

    function automatic bit pending(tag_t t);
        return issued[t] != retired[t] + dropped[t];
    endfunction

    function automatic int in_flight();
        int n;
        n = 0;
        for (int t = 0; t < 16; t++) begin
            if (pending(tag_t'(t))) n++;
        end
        return n;
    endfunction

    // Dest must be idle and not read by anything in flight
    function automatic bit can_dispatch(tag_t d);
        if (pending(d)) return 1'b0;
        for (int t = 0; t < 16; t++) begin
            if (pending(tag_t'(t)) && (pend_s1[t] == d || pend_s2[t] == d)) return 1'b0;
        end
        return 1'b1;
    endfunction

    task automatic stop_run();
        $display("Finished with errors");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(logic [31:0] got, logic [31:0] exp, string what);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s, got %0h expected %0h", $time, what, got, exp);
            stop_run();
        end
    endtask

    // One cycle of waiting, counted against the timeout
    task automatic tick(inout int waited, input string what);
        waited++;
        if (waited > TIMEOUT) begin
            $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
            stop_run();
        end
        @(posedge clock);
        #1;
    endtask

    // Called 1 ns after a rising edge, returns 1 ns after the dispatch edge
    task automatic dispatch(logic [3:0] op, tag_t d, tag_t s1, tag_t s2);
        int waited;
        waited = 0;
        while (stall) begin
            stall_seen = 1'b1;
            tick(waited, "stall to drop");
        end
        pend_op[d] = op;
        pend_s1[d] = s1;
        pend_s2[d] = s2;
        issued[d]++;
        inst_word  = {op, d, s1, s2};
        inst_valid = 1'b1;
        @(posedge clock);
        #1;
        inst_valid = 1'b0;
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (in_flight() != 0) tick(waited, "all results");
    endtask

    //////////////////////////////////////////////////
    // Compare process
    //////////////////////////////////////////////////
    always @(negedge clock) begin
        data_t expected;
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                model_regs[i] = data_t'(i);            // Register i resets to i
            end
        end else if (result_valid) begin
            if (!pending(result_tag)) begin
                $display("Result for r%0d at %0t ns with no instruction in flight",
                         result_tag, $time);
                stop_run();
            end
            expected = ref_alu(pend_op[result_tag], model_regs[pend_s1[result_tag]],
                               model_regs[pend_s2[result_tag]]);
            check_value(32'(result_data), 32'(expected),
                        $sformatf("result for r%0d", result_tag));
            model_regs[result_tag] = expected;
            retired[result_tag]++;
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////
    initial begin
        int          waited;
        logic [31:0] r;
        inst_valid = 1'b0;
        inst_word  = '0;
        flush      = 1'b0;
        waited     = 0;
        while (rst_n !== 1'b1) tick(waited, "reset release");

        // Every opcode plus one unused code, sources r0..r7 all ready
        for (int k = 0; k < 8; k++) begin
            r = $random(seed);
            dispatch((k == 7) ? 4'hC : 4'(k), tag_t'(8 + k), {1'b0, r[2:0]}, {1'b0, r[6:4]});
        end
        drain();

        dispatch(4'h0, 4'd1, 4'd2, 4'd3);              // r1 = r2 + r3
        dispatch(4'h1, 4'd4, 4'd1, 4'd5);              // Waits for r1
        dispatch(4'h4, 4'd6, 4'd4, 4'd1);
        dispatch(4'h5, 4'd7, 4'd6, 4'd2);
        drain();

        // Serial chain r1..r6, then consumers all blocked on r6
        stall_seen = 1'b0;
        for (int k = 0; k < 6; k++) dispatch(4'h0, tag_t'(k + 1), tag_t'(k), tag_t'(k));
        for (int k = 0; k < RS_SIZE; k++) dispatch(4'h3, tag_t'(8 + k), 4'd6, 4'd7);
        check_value(32'(stall_seen), 32'd1, "stall with a full station");
        drain();

        // Random mix, sources may still be in flight
        for (int n = 0; n < 60; n++) begin
            waited = 0;
            r      = $random(seed);
            while (!can_dispatch(r[11:8])) begin
                tick(waited, "a free destination");
                r = $random(seed);
            end
            dispatch(r[15:12], r[11:8], r[7:4], r[3:0]);
        end
        drain();

        // Flush with part of a chain still waiting
        for (int k = 0; k < 6; k++) dispatch(4'h1, tag_t'(k + 1), tag_t'(k), 4'd9);
        flush = 1'b1;
        @(posedge clock);
        #1;
        flush = 1'b0;
        for (int t = 0; t < 16; t++) begin
            if (pending(tag_t'(t))) dropped[t]++;
        end
        for (int c = 0; c < 10; c++) begin
            @(posedge clock);                           // Any result here is unexpected
            #1;
        end
        dispatch(4'h0, 4'd12, 4'd5, 4'd6);              // Flushed dests keep old values
        dispatch(4'h4, 4'd13, 4'd4, 4'd3);
        drain();

        if (in_flight() == 0) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            $display("Instructions still in flight at the end of the run");
            stop_run();
        end
    end

endmodule

`default_nettype wire

// File: ooo_issue.f
design/ooo_issue_pkg.sv
design/slot_allocator.sv
design/inst_decode.sv
design/rs.sv
design/issue_select.sv
design/alu_execute.sv
design/result_bus.sv
design/ooo_issue_top.sv
verif/clock_gen.sv
verif/ooo_issue_properties.sv
verif/ooo_issue_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -j 0 --top-module ooo_issue_tb \
		-f ooo_issue.f -Mdir obj_dir -o ooo_issue_sim
	./obj_dir/ooo_issue_sim 2>&1 | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	fi
	@if ! grep -q "Finished with no errors" $(LOG); then \
		echo "Simulation FAILED, no pass line in $(LOG)"; exit 1; \
	fi
	@echo "Simulation PASSED"

lint:
	verilator --lint-only -Wall --timing --top-module ooo_issue_tb -f ooo_issue.f

clean:
	rm -rf obj_dir $(LOG)
